/* verilog/zbuf_pkg.sv */
// Sizes, element types, encodings and structs shared by the Z buffer slice
// Every RTL module and the testbench import this package
package zbuf_pkg;

  localparam int ZBUF_W = 4;   // Lanes
  localparam int ZBUF_D = 4;   // Elements held per lane
  localparam int ELEM_W = 16;  // Two's-complement integer element

  localparam int LANE_IDX_W  = $clog2(ZBUF_W);
  localparam int DEPTH_IDX_W = $clog2(ZBUF_D);
  localparam int CMD_LFT_W   = DEPTH_IDX_W + 1;  // Wide enough to also hold D

  typedef logic [ELEM_W-1:0] elem_t;
  typedef elem_t [ZBUF_W-1:0] lane_vec_t;   // One element per lane
  typedef elem_t [ZBUF_D-1:0] depth_vec_t;  // Y input row, Z output row

  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,
    OP_CLEAR = 3'd1,
    OP_SET_X = 3'd2,
    OP_LOAD  = 3'd3,
    OP_PUSH  = 3'd4,
    OP_STORE = 3'd5
  } zbuf_op_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_LOAD  = 2'd1,
    ST_PUSH  = 2'd2,
    ST_STORE = 2'd3
  } zbuf_state_e;

  // Single-cycle command from the host
  typedef struct packed {
    logic                 valid;
    zbuf_op_e             op;
    logic [CMD_LFT_W-1:0] cols_lftovr;  // Valid Y elements per row, 0 means all
    lane_vec_t            x;
    elem_t                wt;
  } zbuf_cmd_t;

  // Decoder to buffer
  typedef struct packed {
    logic                   clear;
    logic                   load;
    logic                   y_valid;
    logic                   push;
    logic                   store;
    logic                   ready;
    logic [DEPTH_IDX_W-1:0] cols_lftovr;
  } zbuf_ctrl_t;

  // Buffer to decoder, one-cycle pulses
  typedef struct packed {
    logic loaded;
    logic y_pushed;
    logic empty;
  } zbuf_flags_t;

endpackage

/* verilog/zbuf_cmd_decoder.sv */
`timescale 1ns/1ps
// Decode stage of the Z buffer: accepts commands while idle and steps through
// load, push and store until the buffer flags the end of each one
module zbuf_cmd_decoder
  import zbuf_pkg::*;
(
  input  logic        buffer_clock,
  input  logic        rst_ni,
  input  zbuf_cmd_t   cmd_i,
  input  logic        y_valid_i,
  input  logic        z_ready_i,
  input  zbuf_flags_t flags_i,
  output zbuf_ctrl_t  ctrl_o,
  output logic        set_x_o,
  output logic        busy_o,
  output logic        y_ready_o,
  output logic        z_valid_o
);

  zbuf_state_e            state_q, state_d;
  logic [DEPTH_IDX_W-1:0] lftovr_q;
  logic                   accept;

  // Commands are only taken while idle
  assign accept = cmd_i.valid && (state_q == ST_IDLE);

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          case (cmd_i.op)
            OP_LOAD:  state_d = ST_LOAD;
            OP_PUSH:  state_d = ST_PUSH;
            OP_STORE: state_d = ST_STORE;
            default:  state_d = ST_IDLE;  // NOP, CLEAR, SET_X finish at the edge
          endcase
        end
      end
      ST_LOAD: begin
        if (flags_i.loaded) state_d = ST_IDLE;
      end
      ST_PUSH: begin
        if (flags_i.y_pushed) state_d = ST_IDLE;
      end
      ST_STORE: begin
        if (flags_i.empty) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge buffer_clock or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A value of D in the command truncates to 0, which also selects all columns
  always_ff @(posedge buffer_clock or negedge rst_ni) begin : lftovr_reg
    if (!rst_ni) begin
      lftovr_q <= '0;
    end else if (accept && cmd_i.op == OP_LOAD) begin
      lftovr_q <= cmd_i.cols_lftovr[DEPTH_IDX_W-1:0];
    end
  end

  always_comb begin : ctrl_drive
    ctrl_o.clear       = accept && (cmd_i.op == OP_CLEAR);
    ctrl_o.load        = (state_q == ST_LOAD);
    ctrl_o.y_valid     = (state_q == ST_LOAD) && y_valid_i;
    ctrl_o.push        = (state_q == ST_PUSH);
    ctrl_o.store       = (state_q == ST_STORE);
    ctrl_o.ready       = (state_q == ST_STORE) && z_ready_i;  // Beat completes
    ctrl_o.cols_lftovr = lftovr_q;
  end

  assign set_x_o   = accept && (cmd_i.op == OP_SET_X);  // Lanes latch X and wt
  assign busy_o    = (state_q != ST_IDLE);
  assign y_ready_o = (state_q == ST_LOAD);
  assign z_valid_o = (state_q == ST_STORE);

endmodule

/* verilog/zbuf_mac_lanes.sv */
`timescale 1ns/1ps
// Execute stage of the Z buffer: W integer multiply-add lanes computing y + x*wt
// on the element leaving each lane during a push
module zbuf_mac_lanes
  import zbuf_pkg::*;
(
  input  logic      buffer_clock,
  input  logic      rst_ni,
  input  logic      set_x_i,
  input  lane_vec_t x_i,
  input  elem_t     wt_i,
  input  lane_vec_t y_lane_i,
  output lane_vec_t fill_lane_o
);

  lane_vec_t x_q;
  elem_t     wt_q;
  lane_vec_t prod;

  // X vector and weight stay until the next SET_X
  always_ff @(posedge buffer_clock or negedge rst_ni) begin : operand_regs
    if (!rst_ni) begin
      x_q  <= '0;
      wt_q <= '0;
    end else if (set_x_i) begin
      x_q  <= x_i;
      wt_q <= wt_i;
    end
  end

  // Arithmetic wraps at 16 bits, so only the low half of each product matters
  always_comb begin : lane_mac
    for (int w = 0; w < ZBUF_W; w++) begin
      prod[w]        = x_q[w] * wt_q;
      fill_lane_o[w] = y_lane_i[w] + prod[w];
    end
  end

endmodule

/* verilog/zbuf_result_buffer.sv */
`timescale 1ns/1ps
// Result stage of the Z buffer: D-by-W element array loaded by columns,
// rotated through the MAC lanes on push and drained lane by lane on store
module zbuf_result_buffer
  import zbuf_pkg::*;
(
  input  logic        buffer_clock,
  input  logic        rst_ni,
  input  zbuf_ctrl_t  ctrl_i,
  input  depth_vec_t  y_data_i,
  input  lane_vec_t   fill_lane_i,
  output lane_vec_t   y_lane_o,
  output depth_vec_t  z_data_o,
  output zbuf_flags_t flags_o
);

  lane_vec_t [ZBUF_D-1:0] zbuf_q;     // Indexed [depth slot][lane]
  logic [LANE_IDX_W-1:0]  w_index;    // Lane taking the next Y row
  logic [DEPTH_IDX_W-1:0] d_index;    // Push step
  logic [LANE_IDX_W-1:0]  store_cnt;  // Rows already sent out
  logic [DEPTH_IDX_W:0]   depth;
  logic                   load_beat;
  logic                   store_beat;
  logic                   loaded;
  logic                   y_pushed;
  logic                   empty;

  assign load_beat  = ctrl_i.load && ctrl_i.y_valid;
  assign store_beat = ctrl_i.store && ctrl_i.ready;

  // Number of Y elements kept per row
  assign depth = (ctrl_i.cols_lftovr == '0) ? (DEPTH_IDX_W+1)'(ZBUF_D)
                                            : {1'b0, ctrl_i.cols_lftovr};

  always_ff @(posedge buffer_clock or negedge rst_ni) begin : z_array
    if (!rst_ni) begin
      zbuf_q <= '0;
    end else if (ctrl_i.clear) begin
      zbuf_q <= '0;
    end else if (ctrl_i.push) begin
      // Slot D-1 goes to the lanes and comes back updated into slot 0
      for (int d = ZBUF_D-1; d > 0; d--) begin
        zbuf_q[d] <= zbuf_q[d-1];
      end
      zbuf_q[0] <= fill_lane_i;
    end else if (store_beat) begin
      for (int d = 0; d < ZBUF_D; d++) begin
        for (int w = 0; w < ZBUF_W-1; w++) begin
          zbuf_q[d][w] <= zbuf_q[d][w+1];  // Shift toward lane 0
        end
        zbuf_q[d][ZBUF_W-1] <= '0;
      end
    end else if (load_beat) begin
      for (int d = 0; d < ZBUF_D; d++) begin
        zbuf_q[ZBUF_D-1-d][w_index] <= (d < depth) ? y_data_i[d] : '0;
      end
    end
  end

  // Flags fire on the last event of each operation
  assign loaded   = load_beat && (w_index == LANE_IDX_W'(ZBUF_W-1));
  assign y_pushed = ctrl_i.push && (d_index == DEPTH_IDX_W'(ZBUF_D-1));
  assign empty    = store_beat && (store_cnt == LANE_IDX_W'(ZBUF_W-1));

  always_ff @(posedge buffer_clock or negedge rst_ni) begin : load_counter
    if (!rst_ni) begin
      w_index <= '0;
    end else if (ctrl_i.clear || loaded) begin
      w_index <= '0;
    end else if (load_beat) begin
      w_index <= w_index + 1'b1;
    end
  end

  always_ff @(posedge buffer_clock or negedge rst_ni) begin : push_counter
    if (!rst_ni) begin
      d_index <= '0;
    end else if (ctrl_i.clear || y_pushed) begin
      d_index <= '0;
    end else if (ctrl_i.push) begin
      d_index <= d_index + 1'b1;
    end
  end

  always_ff @(posedge buffer_clock or negedge rst_ni) begin : store_counter
    if (!rst_ni) begin
      store_cnt <= '0;
    end else if (ctrl_i.clear || empty) begin
      store_cnt <= '0;
    end else if (store_beat) begin
      store_cnt <= store_cnt + 1'b1;
    end
  end

  assign flags_o.loaded   = loaded;
  assign flags_o.y_pushed = y_pushed;
  assign flags_o.empty    = empty;

  // Lanes only see data during a push
  assign y_lane_o = ctrl_i.push ? zbuf_q[ZBUF_D-1] : '0;

  // Output row comes from lane 0, in load order
  always_comb begin : z_row
    for (int d = 0; d < ZBUF_D; d++) begin
      z_data_o[d] = zbuf_q[ZBUF_D-1-d][0];
    end
  end

endmodule

/* verilog/zbuf_top.sv */
`timescale 1ns/1ps
// Top level of the Z buffer accumulation slice
// Commands drive the decoder, Y rows stream in and Z rows stream out
module zbuf_top
  import zbuf_pkg::*;
(
  input  logic       buffer_clock,
  input  logic       rst_ni,
  input  zbuf_cmd_t  cmd_i,
  input  depth_vec_t y_data_i,
  input  logic       y_valid_i,
  input  logic       z_ready_i,
  output logic       busy_o,
  output logic       y_ready_o,
  output depth_vec_t z_data_o,
  output logic       z_valid_o
);

  zbuf_ctrl_t  ctrl;
  zbuf_flags_t flags;
  logic        set_x;
  lane_vec_t   y_lane;     // Elements leaving the buffer on push
  lane_vec_t   fill_lane;  // Updated elements coming back

  zbuf_cmd_decoder u_decoder (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .cmd_i        ( cmd_i        ),
    .y_valid_i    ( y_valid_i    ),
    .z_ready_i    ( z_ready_i    ),
    .flags_i      ( flags        ),
    .ctrl_o       ( ctrl         ),
    .set_x_o      ( set_x        ),
    .busy_o       ( busy_o       ),
    .y_ready_o    ( y_ready_o    ),
    .z_valid_o    ( z_valid_o    )
  );

  zbuf_mac_lanes u_lanes (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .set_x_i      ( set_x        ),
    .x_i          ( cmd_i.x      ),
    .wt_i         ( cmd_i.wt     ),
    .y_lane_i     ( y_lane       ),
    .fill_lane_o  ( fill_lane    )
  );

  zbuf_result_buffer u_buffer (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .ctrl_i       ( ctrl         ),
    .y_data_i     ( y_data_i     ),
    .fill_lane_i  ( fill_lane    ),
    .y_lane_o     ( y_lane       ),
    .z_data_o     ( z_data_o     ),
    .flags_o      ( flags        )
  );

endmodule

/* sim/zbuf_clk_gen.sv */
`timescale 1ns/1ps
// Testbench clock and reset for the Z buffer, 20 ns period
// Reset is held low for 8 cycles and released on a falling edge
module zbuf_clk_gen (
  output logic buffer_clock_o,
  output logic rst_no
);

  initial begin
    buffer_clock_o = 1'b0;
    forever #10 buffer_clock_o = ~buffer_clock_o;  // Half of the 20 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge buffer_clock_o);
    @(negedge buffer_clock_o);
    rst_no = 1'b1;
  end

endmodule

/* sim/zbuf_asserts.sv */
`timescale 1ns/1ps
// Concurrent checks on the Z buffer handshakes, bound into zbuf_top
// Each failing property also bumps fail_cnt
module zbuf_asserts
  import zbuf_pkg::*;
(
  input logic       buffer_clock,
  input logic       rst_ni,
  input zbuf_ctrl_t ctrl_i,
  input logic       y_ready_i,
  input logic       z_valid_i,
  input logic       z_ready_i,
  input depth_vec_t z_data_i
);

  int unsigned fail_cnt = 0;

  // Load and store never overlap
  assert property (@(posedge buffer_clock) disable iff (!rst_ni)
    !(y_ready_i && z_valid_i))
    else begin
      $error("y_ready_o and z_valid_o are high in the same cycle");
      fail_cnt++;
    end

  // Push rotates the whole depth exactly once
  assert property (@(posedge buffer_clock) disable iff (!rst_ni)
    $rose(ctrl_i.push) |-> ctrl_i.push [*ZBUF_D] ##1 !ctrl_i.push)
    else begin
      $error("Push control did not last exactly D cycles");
      fail_cnt++;
    end

  assert property (@(posedge buffer_clock) disable iff (!rst_ni)
    z_valid_i && !z_ready_i |=> $stable(z_data_i) && z_valid_i)
    else begin
      $error("Z output changed while stalled");
      fail_cnt++;
    end

endmodule

/* sim/zbuf_tb.sv */
`timescale 1ns/1ps
// Testbench for the Z buffer slice: loads, pushes and stores rows against a
// reference array and compares every completed Z beat
module zbuf_tb
  import zbuf_pkg::*;
();

  logic       buffer_clock;
  logic       rst_ni;
  zbuf_cmd_t  cmd;
  depth_vec_t y_data;
  logic       y_valid;
  logic       z_ready;
  logic       busy;
  logic       y_ready;
  depth_vec_t z_data;
  logic       z_valid;

  elem_t       ref_z [ZBUF_D][ZBUF_W];  // Expected array, [slot][lane]
  lane_vec_t   cur_x;
  elem_t       cur_wt;
  depth_vec_t  exp_q [$];
  depth_vec_t  exp_row;
  int unsigned n_cmds = 25;              // Commands issued by the sequence below
  int unsigned n_beats = 18 * ZBUF_W;    // Nine loads and nine stores

  zbuf_clk_gen u_clk_gen (
    .buffer_clock_o ( buffer_clock ),
    .rst_no         ( rst_ni       )
  );

  zbuf_top u_dut (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .cmd_i        ( cmd          ),
    .y_data_i     ( y_data       ),
    .y_valid_i    ( y_valid      ),
    .z_ready_i    ( z_ready      ),
    .busy_o       ( busy         ),
    .y_ready_o    ( y_ready      ),
    .z_data_o     ( z_data       ),
    .z_valid_o    ( z_valid      )
  );

  bind zbuf_top zbuf_asserts u_asserts (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .ctrl_i       ( ctrl         ),
    .y_ready_i    ( y_ready_o    ),
    .z_valid_i    ( z_valid_o    ),
    .z_ready_i    ( z_ready_i    ),
    .z_data_i     ( z_data_o     )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Multiply-add with 16-bit wraparound
  function automatic elem_t mac_elem(input elem_t y, input elem_t x, input elem_t wt);
    logic [31:0] full;
    full = 32'(y) + 32'(x) * 32'(wt);
    return full[ELEM_W-1:0];
  endfunction

  // Row sent out by store beat number lane, in load order
  function automatic depth_vec_t ref_row(input int lane);
    depth_vec_t row;
    for (int d = 0; d < ZBUF_D; d++) begin
      row[d] = ref_z[ZBUF_D-1-d][lane];
    end
    return row;
  endfunction

  function automatic depth_vec_t random_row();
    depth_vec_t row;
    for (int d = 0; d < ZBUF_D; d++) begin
      row[d] = elem_t'($urandom);
    end
    return row;
  endfunction

  task automatic clear_model();
    for (int d = 0; d < ZBUF_D; d++) begin
      for (int w = 0; w < ZBUF_W; w++) ref_z[d][w] = '0;
    end
  endtask

  // Called on a falling edge with the DUT idle; returns one cycle later
  task automatic issue_cmd(input zbuf_op_e op, input int cols, input lane_vec_t x,
                           input elem_t wt);
    assert (!busy) else stop_on_error("Command issued while the DUT was still busy");
    cmd.valid       = 1'b1;
    cmd.op          = op;
    cmd.cols_lftovr = CMD_LFT_W'(cols);
    cmd.x           = x;
    cmd.wt          = wt;
    @(negedge buffer_clock);
    cmd = '0;
  endtask

  task automatic load_rows(input int cols);
    depth_vec_t row;
    int beats;
    beats = 0;
    issue_cmd(OP_LOAD, cols, '0, '0);
    while (beats < ZBUF_W) begin
      row    = random_row();
      y_data = row;
      if (y_ready && ($urandom % 4 != 0)) begin  // Random gaps in y_valid
        y_valid = 1'b1;
        for (int d = 0; d < ZBUF_D; d++) begin
          ref_z[ZBUF_D-1-d][beats] = (cols == 0 || d < cols) ? row[d] : '0;
        end
        beats++;
      end else begin
        y_valid = 1'b0;
      end
      @(negedge buffer_clock);
    end
    y_valid = 1'b0;
    assert (!busy && !y_ready) else stop_on_error("Load did not end after W beats");
  endtask

  task automatic set_operands();
    cur_x  = lane_vec_t'({$urandom, $urandom});
    cur_wt = elem_t'($urandom);
    issue_cmd(OP_SET_X, 0, cur_x, cur_wt);
    assert (!busy) else stop_on_error("SET_X left the DUT busy");
  endtask

  task automatic push_rows();
    int cycles;
    cycles = 0;
    issue_cmd(OP_PUSH, 0, '0, '0);
    while (busy) begin
      cycles++;
      @(negedge buffer_clock);
    end
    assert (cycles == ZBUF_D)
      else stop_on_error($sformatf("[ERROR] busy_o push cycles: got 0x%h, expected 0x%h",
                                   cycles, ZBUF_D));
    for (int d = 0; d < ZBUF_D; d++) begin
      for (int w = 0; w < ZBUF_W; w++) ref_z[d][w] = mac_elem(ref_z[d][w], cur_x[w], cur_wt);
    end
  endtask

  task automatic store_rows(input bit stall);
    int beats;
    beats = 0;
    for (int w = 0; w < ZBUF_W; w++) exp_q.push_back(ref_row(w));
    clear_model();  // Store drains the buffer to zero
    issue_cmd(OP_STORE, 0, '0, '0);
    while (beats < ZBUF_W) begin
      assert (busy && z_valid) else stop_on_error("Store ended before W beats");
      if (!stall || ($urandom % 2 == 0)) begin
        z_ready = 1'b1;
        beats++;
      end else begin
        z_ready = 1'b0;
      end
      @(negedge buffer_clock);
    end
    z_ready = 1'b0;
    assert (!busy && !z_valid) else stop_on_error("Store still busy after W beats");
    assert (exp_q.size() == 0) else stop_on_error("Store dropped a beat");
  endtask

  always @(posedge buffer_clock) begin : z_compare
    if (rst_ni && z_valid && z_ready) begin
      assert (exp_q.size() > 0) else stop_on_error("Z beat completed with no row expected");
      exp_row = exp_q.pop_front();
      assert (z_data == exp_row)
        else stop_on_error($sformatf("[ERROR] z_data_o: got 0x%h, expected 0x%h",
                                     z_data, exp_row));
    end
  end

  always @(u_dut.u_asserts.fail_cnt) begin : assert_watch
    if (u_dut.u_asserts.fail_cnt != 0) begin
      stop_on_error("A concurrent assertion on the DUT failed");
    end
  end

  initial begin : watchdog
    int unsigned limit;
    limit = 16 + n_cmds * (ZBUF_D + 4) + n_beats * 8;
    repeat (limit) @(posedge buffer_clock);
    stop_on_error("Watchdog timeout, the test sequence did not finish in time");
  end

  initial begin : stimulus
    void'($urandom(32'h03b2b5ce));
    cmd     = '0;
    y_data  = '0;
    y_valid = 1'b0;
    z_ready = 1'b0;
    cur_x   = '0;
    cur_wt  = '0;
    clear_model();
    wait (rst_ni);
    @(negedge buffer_clock);
    assert (!busy && !y_ready && !z_valid) else stop_on_error("Outputs active after reset");
    assert (z_data == '0)
      else stop_on_error($sformatf("[ERROR] z_data_o: got 0x%h, expected 0x0", z_data));

    for (int r = 0; r < 3; r++) begin  // Load then store, with stalls
      load_rows(0);
      store_rows(1'b1);
    end
    for (int c = 1; c < ZBUF_D; c++) begin  // Leftover columns
      load_rows(c);
      store_rows(1'b1);
    end
    load_rows(0);  // Accumulate three rank-1 products
    for (int k = 0; k < 3; k++) begin
      set_operands();
      push_rows();
    end
    store_rows(1'b1);
    load_rows(0);  // Clear wipes loaded data
    issue_cmd(OP_CLEAR, 0, '0, '0);
    assert (!busy) else stop_on_error("CLEAR left the DUT busy");
    clear_model();
    store_rows(1'b0);
    load_rows(0);
    store_rows(1'b1);

    repeat (4) @(negedge buffer_clock);
    if (u_dut.u_asserts.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/zbuf_pkg.sv
verilog/zbuf_cmd_decoder.sv
verilog/zbuf_mac_lanes.sv
verilog/zbuf_result_buffer.sv
verilog/zbuf_top.sv
sim/zbuf_clk_gen.sv
sim/zbuf_asserts.sv
sim/zbuf_tb.sv

/* Bender.yml */
package:
  name: zbuf

sources:
  - verilog/zbuf_pkg.sv
  - verilog/zbuf_cmd_decoder.sv
  - verilog/zbuf_mac_lanes.sv
  - verilog/zbuf_result_buffer.sv
  - verilog/zbuf_top.sv
  - target: simulation
    files:
      - sim/zbuf_clk_gen.sv
      - sim/zbuf_asserts.sv
      - sim/zbuf_tb.sv
